/* src.f */
+incdir+test
logic/misao_pkg.sv
logic/nibble_fetch.sv
logic/operand_collector.sv
logic/misao_control.sv
logic/linked_alu.sv
logic/misao_top.sv
test/misao_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -Wno-fatal --top-module misao_tb -f src.f -o misao_sim
./obj_dir/misao_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
else
    echo "simulation did not pass"
    exit 1
fi

/* test/misao_tasks.svh */
    // One nibble at the program cursor
    task automatic put_nibble(logic [3:0] v);
        if (prog_pc % 2 == 1) begin
            mem[prog_pc / 2][7:4] = v;
        end else begin
            mem[prog_pc / 2][3:0] = v;
        end
        prog_pc++;
    endtask

    task automatic put_operand(int val);   // Low nibble first
        for (int n = 0; n < m_w / 4; n++) begin
            put_nibble(4'(val >> (4 * n)));
        end
    endtask

    function automatic bit takes_source(op_e op);
        return op inside {ADD, SUB, AND, OR, XOR};
    endfunction

    // Expected result of one executed operation at the current width
    task automatic model_op(op_e op, int src);
        int mask;
        int a;
        int s;
        int cin;
        int res;
        mask = (1 << m_w) - 1;
        a    = m_acc & mask;
        s    = src & mask;
        cin  = m_cen & m_carry;
        case (op)
            LDI:     res = s;
            ADD:     res = a + s + cin;
            SUB:     res = a - s - cin;
            INC:     res = a + 1;
            DEC:     res = a - 1;
            SHL:     res = a << 1;
            SHR:     res = a >> 1;
            AND:     res = a & s;
            OR:      res = a | s;
            XOR:     res = a ^ s;
            INV:     res = ~a;
            SS:      res = m_rs0;
            default: res = a;
        endcase
        if (op inside {ADD, INC, SHL}) begin
            m_carry = (res >> m_w) & 1;
        end else if (op inside {SUB, DEC}) begin
            m_carry = (res < 0) ? 1 : 0;     // Borrow
        end else if (op == SHR) begin
            m_carry = a & 1;
        end
        if (op == SS) begin
            m_rs0 = (m_rs0 & ~mask) | a;
        end
        m_acc = (m_acc & ~mask) | (res & mask);   // Upper nibbles kept
    endtask

    task automatic cfg_instr(logic cen, logic imm, logic [1:0] lk);
        logic [7:0] b;
        b = '0;
        b[CFG_CEN_BIT] = cen;
        b[CFG_IMM_BIT] = imm;
        b[CFG_LINK_LSB +: 2] = lk;
        put_nibble(4'(CFG));
        put_nibble(b[3:0]);
        put_nibble(b[7:4]);
        m_cen = cen;
        m_imm = imm;
        m_w   = (lk == 2'd0) ? 4 : (lk == 2'd1) ? 8 : 16;
    endtask

    task automatic ldi_instr(int val);
        put_nibble(4'(LDI));
        put_operand(val);
        model_op(LDI, val);
    endtask

    task automatic alu_instr(op_e op, int val);
        logic [4:0] code;
        int         src;
        code = op;
        if (code[4]) begin
            put_nibble(4'(XOP));
        end
        put_nibble(code[3:0]);
        src = m_rs0;
        if (takes_source(op) && m_imm != 0) begin
            put_operand(val);
            src = val;
        end
        model_op(op, src);
    endtask

    // NOP fill, model reset, then reset asserted
    task automatic begin_program(string name);
        cur_test = name;
        budget += 18;
        for (int i = 0; i < (1 << ADDR_W); i++) begin
            mem[i] = 8'h00;
        end
        m_acc   = 0;
        m_rs0   = 0;
        m_carry = 0;
        m_cen   = CEN_RESET;
        m_imm   = IMM_RESET;
        m_w     = 4;
        prog_pc = RESET_PC;
        @(posedge clk);
        rst <= 1'b1;
    endtask

    task automatic run_program();
        int len;
        len = prog_pc - RESET_PC;
        budget += len;
        repeat (9) @(posedge clk);
        @(negedge clk);
        check_value("acc after reset", 0, test_data);
        check_value("carry after reset", 0, test_carry);
        @(posedge clk);
        rst <= 1'b0;
        repeat (len + 8) @(posedge clk);   // One nibble per cycle
        @(negedge clk);
        check_value("acc", m_acc, test_data);
        check_value("carry", m_carry, test_carry);
    endtask

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch in %s, %s: expected %h actual %h",
                     cur_test, what, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic ldi_widths();
        begin_program("ldi at reset width");
        ldi_instr(32'h5A57);
        run_program();
        begin_program("ldi over three widths");
        cfg_instr(1'b1, 1'b0, LK16);
        ldi_instr(32'h1234);
        cfg_instr(1'b1, 1'b0, LK8);
        ldi_instr(32'h99AB);
        cfg_instr(1'b1, 1'b0, UL);
        ldi_instr(32'h000C);
        run_program();
    endtask

    task automatic add_sub_registers();
        for (int lk = 0; lk < 3; lk++) begin
            for (int cen = 0; cen < 2; cen++) begin
                begin_program($sformatf("add carry link %0d cen %0d", lk, cen));
                cfg_instr(1'(cen), 1'b0, 2'(lk));
                ldi_instr(32'hFFFF);
                alu_instr(SS, 0);
                ldi_instr(2);
                alu_instr(ADD, 0);      // Wraps with carry
                alu_instr(ADD, 0);
                run_program();
                begin_program($sformatf("sub borrow link %0d cen %0d", lk, cen));
                cfg_instr(1'(cen), 1'b0, 2'(lk));
                ldi_instr(1);
                alu_instr(SS, 0);
                alu_instr(SUB, 0);      // 0 - 1 borrows
                alu_instr(SUB, 0);
                run_program();
                begin_program($sformatf("add sub random link %0d cen %0d", lk, cen));
                cfg_instr(1'(cen), 1'b0, 2'(lk));
                ldi_instr($random(seed));
                alu_instr(SS, 0);
                ldi_instr($random(seed));
                alu_instr(ADD, 0);
                alu_instr(SUB, 0);
                run_program();
            end
        end
    endtask

    task automatic immediate_ops();
        op_e ops [5];
        ops = '{ADD, SUB, AND, OR, XOR};
        for (int lk = 0; lk < 3; lk++) begin
            for (int i = 0; i < 5; i++) begin
                begin_program($sformatf("imm %s link %0d", ops[i].name(), lk));
                cfg_instr(1'b1, 1'b1, 2'(lk));
                ldi_instr($random(seed));
                alu_instr(ops[i], 32'h94E2);   // Operand nibbles look like opcodes
                alu_instr(ops[i], $random(seed));
                run_program();
            end
        end
    endtask

    task automatic unary_ops();
        op_e ops [5];
        int  start;
        ops = '{INC, DEC, INV, SHL, SHR};
        for (int lk = 0; lk < 3; lk++) begin
            for (int i = 0; i < 5; i++) begin
                for (int k = 0; k < 3; k++) begin
                    begin_program($sformatf("%s link %0d start %0d", ops[i].name(), lk, k));
                    start = (k == 0) ? 0 : (k == 1) ? 32'hFFFF : $random(seed);
                    cfg_instr(1'b1, 1'b0, LK16);
                    ldi_instr($random(seed));          // Upper nibbles to keep
                    cfg_instr(1'b1, 1'b0, 2'(lk));
                    ldi_instr(start);
                    alu_instr(ops[i], 0);
                    alu_instr(ops[i], 0);
                    run_program();
                end
            end
        end
    endtask

    task automatic swap_width();
        for (int lk = 0; lk < 3; lk++) begin
            for (int v = 0; v < 2; v++) begin
                begin_program($sformatf("ss link %0d variant %0d", lk, v));
                cfg_instr(1'b1, 1'b0, LK16);
                ldi_instr($random(seed));
                alu_instr(SS, 0);
                ldi_instr($random(seed));
                cfg_instr(1'b1, 1'b0, 2'(lk));
                alu_instr(SS, 0);                      // Low bits only
                cfg_instr(1'b1, 1'b0, LK16);
                alu_instr((v == 0) ? SS : ADD, 0);
                run_program();
            end
        end
    endtask

    task automatic random_immediates();
        op_e ops [5];
        int  idx;
        ops = '{ADD, SUB, AND, OR, XOR};
        begin_program("random immediates");
        cfg_instr(1'b1, 1'b1, LK16);
        ldi_instr($random(seed));
        repeat (20) begin
            idx = $unsigned($random(seed)) % 5;
            alu_instr(ops[idx], $random(seed));
        end
        run_program();
    endtask

/* test/misao_tb.sv */
`timescale 1ns/1ps

module misao_tb;
    import misao_pkg::*;

    logic              clk;
    logic              rst;
    logic [7:0]        mem_data_in;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] test_data;
    logic              test_carry;

    logic [7:0] mem [0:(1 << ADDR_W) - 1];   // 32K bytes

    // Reference model state
    int m_acc;
    int m_rs0;
    int m_carry;
    int m_cen;
    int m_imm;
    int m_w;            // Operating width in bits

    int     prog_pc;    // Next nibble address to write
    string  cur_test;
    int     budget;     // Expected cycles so far
    int     cycles;
    integer seed;

    `include "misao_tasks.svh"

    assign mem_data_in = mem[mem_addr];   // Asynchronous read

    misao_top misao_top_i (
        .clk         (clk),
        .rst         (rst),
        .mem_data_in (mem_data_in),
        .mem_addr    (mem_addr),
        .test_data   (test_data),
        .test_carry  (test_carry)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog at twice the cycles the programs need
    initial begin
        cycles = 0;
        while (cycles <= 2 * budget) begin
            @(posedge clk);
            cycles++;
        end
        $display("watchdog expired after %0d cycles in %s", cycles, cur_test);
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        rst    = 1'b1;
        budget = 0;
        seed   = 32'hb1e5d33f;
        ldi_widths();
        add_sub_registers();
        immediate_ops();
        unary_ops();
        swap_width();
        random_immediates();
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* logic/misao_top.sv */
`timescale 1ns/1ps

module misao_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [7:0]                   mem_data_in,
    output logic [misao_pkg::ADDR_W-1:0] mem_addr,
    output logic [misao_pkg::DATA_W-1:0] test_data,
    output logic                         test_carry
);
    import misao_pkg::*;

    logic [NIBBLE_W-1:0] nibble;
    logic                collect_start;
    count_t              collect_count;
    logic                collect_done;
    logic [DATA_W-1:0]   collect_value;
    logic                exec;
    op_e                 exec_op;
    logic                use_imm;
    link_e               link;
    logic                carry_en;

    nibble_fetch fetch_i (
        .clk         (clk),
        .rst         (rst),
        .mem_data_in (mem_data_in),
        .mem_addr    (mem_addr),
        .nibble      (nibble)
    );

    operand_collector collector_i (
        .clk           (clk),
        .rst           (rst),
        .nibble        (nibble),
        .collect_start (collect_start),
        .collect_count (collect_count),
        .collect_done  (collect_done),
        .collect_value (collect_value)
    );

    misao_control control_i (
        .clk           (clk),
        .rst           (rst),
        .nibble        (nibble),
        .collect_done  (collect_done),
        .collect_value (collect_value),
        .collect_start (collect_start),
        .collect_count (collect_count),
        .exec          (exec),
        .exec_op       (exec_op),
        .use_imm       (use_imm),
        .link          (link),
        .carry_en      (carry_en)
    );

    // Immediate comes straight from the collector
    linked_alu alu_i (
        .clk        (clk),
        .rst        (rst),
        .exec       (exec),
        .exec_op    (exec_op),
        .use_imm    (use_imm),
        .imm        (collect_value),
        .link       (link),
        .carry_en   (carry_en),
        .test_data  (test_data),
        .test_carry (test_carry)
    );

endmodule

/* logic/linked_alu.sv */
`timescale 1ns/1ps

module linked_alu (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         exec,
    input  misao_pkg::op_e               exec_op,
    input  logic                         use_imm,
    input  logic [misao_pkg::DATA_W-1:0] imm,
    input  misao_pkg::link_e             link,
    input  logic                         carry_en,
    output logic [misao_pkg::DATA_W-1:0] test_data,
    output logic                         test_carry
);
    import misao_pkg::*;

    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] rs0;
    logic              carry;

    logic [DATA_W-1:0] mask;
    int                top_bit;    // Carry position for the width
    logic [DATA_W-1:0] acc_m;
    logic [DATA_W-1:0] src_m;
    logic              cin;
    logic [DATA_W:0]   wide;
    logic [DATA_W-1:0] res;
    logic [DATA_W-1:0] acc_next;
    logic [DATA_W-1:0] rs0_next;
    logic              carry_next;

    // Operating width from the link mode
    always_comb begin
        case (link)
            UL: begin
                mask    = {{(DATA_W-NIBBLE_W){1'b0}}, {NIBBLE_W{1'b1}}};
                top_bit = NIBBLE_W;
            end
            LK8: begin
                mask    = {{(DATA_W-2*NIBBLE_W){1'b0}}, {(2*NIBBLE_W){1'b1}}};
                top_bit = 2 * NIBBLE_W;
            end
            default: begin
                mask    = '1;
                top_bit = DATA_W;
            end
        endcase
    end

    assign acc_m = acc & mask;
    assign src_m = (use_imm ? imm : rs0) & mask;
    assign cin   = carry_en & carry;

    always_comb begin
        wide       = '0;
        res        = acc_m;
        rs0_next   = rs0;
        carry_next = carry;
        case (exec_op)
            LDI: res = src_m;
            ADD: begin
                wide       = {1'b0, acc_m} + {1'b0, src_m} + {{DATA_W{1'b0}}, cin};
                res        = wide[DATA_W-1:0];
                carry_next = wide[top_bit];
            end
            SUB: begin
                wide       = {1'b0, acc_m} - {1'b0, src_m} - {{DATA_W{1'b0}}, cin};
                res        = wide[DATA_W-1:0];
                carry_next = wide[DATA_W];     // Borrow
            end
            INC: begin
                wide       = {1'b0, acc_m} + {{DATA_W{1'b0}}, 1'b1};
                res        = wide[DATA_W-1:0];
                carry_next = wide[top_bit];
            end
            DEC: begin
                wide       = {1'b0, acc_m} - {{DATA_W{1'b0}}, 1'b1};
                res        = wide[DATA_W-1:0];
                carry_next = wide[DATA_W];
            end
            SHL: begin
                wide       = {acc_m, 1'b0};
                res        = wide[DATA_W-1:0];
                carry_next = wide[top_bit];    // Bit leaving the width
            end
            SHR: begin
                res        = acc_m >> 1;
                carry_next = acc_m[0];
            end
            AND: res = acc_m & src_m;
            OR:  res = acc_m | src_m;
            XOR: res = acc_m ^ src_m;
            INV: res = ~acc_m;
            SS: begin
                res      = rs0;
                rs0_next = (rs0 & ~mask) | acc_m;
            end
            default: ;
        endcase
        // Nibbles above the width stay put
        acc_next = (acc & ~mask) | (res & mask);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc   <= '0;
            rs0   <= '0;
            carry <= 1'b0;
        end else if (exec) begin
            acc   <= acc_next;
            rs0   <= rs0_next;
            carry <= carry_next;
        end
    end

    assign test_data  = acc;
    assign test_carry = carry;

endmodule

/* logic/misao_control.sv */
`timescale 1ns/1ps

module misao_control (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [misao_pkg::NIBBLE_W-1:0] nibble,
    input  logic                           collect_done,
    input  logic [misao_pkg::DATA_W-1:0]   collect_value,
    output logic                           collect_start,
    output misao_pkg::count_t              collect_count,
    output logic                           exec,
    output misao_pkg::op_e                 exec_op,
    output logic                           use_imm,
    output misao_pkg::link_e               link,
    output logic                           carry_en
);
    import misao_pkg::*;

    op_e  instr;
    logic xop_flag;
    logic imm_mode;
    logic pending;      // Collector owns the following nibbles
    logic pend_cfg;
    op_e  pend_op;
    logic is_binary;

    assign instr = op_e'({xop_flag, nibble});

    always_comb begin
        case (instr)
            ADD, SUB, AND, OR, XOR: is_binary = 1'b1;
            default:                is_binary = 1'b0;
        endcase
    end

    assign collect_start = !pending &&
                           ((instr == LDI) || (instr == CFG) || (is_binary && imm_mode));

    // CFG always takes one byte
    always_comb begin
        if (instr == CFG) begin
            collect_count = 2'd1;
        end else begin
            case (link)
                UL:      collect_count = 2'd0;
                LK8:     collect_count = 2'd1;
                default: collect_count = 2'd3;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            xop_flag <= 1'b0;
            imm_mode <= IMM_RESET;
            carry_en <= CEN_RESET;
            link     <= UL;
            pending  <= 1'b0;
            pend_cfg <= 1'b0;
            pend_op  <= LDI;
            exec     <= 1'b0;
            exec_op  <= LDI;
            use_imm  <= 1'b0;
        end else begin
            exec <= 1'b0;
            if (pending) begin
                if (collect_done) begin
                    pending <= 1'b0;
                    if (pend_cfg) begin
                        carry_en <= collect_value[CFG_CEN_BIT];
                        imm_mode <= collect_value[CFG_IMM_BIT];
                        link     <= link_e'(collect_value[CFG_LINK_LSB +: 2]);
                    end else begin
                        exec    <= 1'b1;      // LDI or immediate ALU op
                        exec_op <= pend_op;
                        use_imm <= 1'b1;
                    end
                end
            end else begin
                xop_flag <= (instr == XOP);
                if (collect_start) begin
                    pending  <= 1'b1;
                    pend_cfg <= (instr == CFG);
                    pend_op  <= instr;
                end else begin
                    case (instr)
                        ADD, SUB, AND, OR, XOR, INC, DEC, INV, SHL, SHR, SS: begin
                            exec    <= 1'b1;
                            exec_op <= instr;
                            use_imm <= 1'b0;
                        end
                        default: ;  // XOP prefix and NOPs
                    endcase
                end
            end
        end
    end

endmodule

/* logic/operand_collector.sv */
`timescale 1ns/1ps

module operand_collector (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [misao_pkg::NIBBLE_W-1:0] nibble,
    input  logic                           collect_start,
    input  misao_pkg::count_t              collect_count,
    output logic                           collect_done,
    output logic [misao_pkg::DATA_W-1:0]   collect_value
);
    import misao_pkg::*;

    logic              busy;
    count_t            index;      // Next nibble position
    count_t            last;
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] merged;

    // Current nibble dropped into its slot
    always_comb begin
        merged = word;
        merged[index*NIBBLE_W +: NIBBLE_W] = nibble;
    end

    assign collect_done  = busy && (index == last);
    assign collect_value = busy ? merged : word;   // Completed word stays after done

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            index <= '0;
            last  <= '0;
        end else if (collect_start) begin
            busy  <= 1'b1;
            index <= '0;
            last  <= collect_count;
        end else if (busy) begin
            index <= index + 1'b1;
            if (collect_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (collect_start) begin
            word <= '0;
        end else if (busy) begin
            word <= merged;
        end
    end

endmodule

/* logic/nibble_fetch.sv */
`timescale 1ns/1ps

module nibble_fetch (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [7:0]                     mem_data_in,
    output logic [misao_pkg::ADDR_W-1:0]   mem_addr,
    output logic [misao_pkg::NIBBLE_W-1:0] nibble
);
    import misao_pkg::*;

    logic [PC_W-1:0] pc;

    // One nibble per cycle, never stalls
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc + 1'b1;
        end
    end

    // Half a cycle for the memory to answer
    always_ff @(negedge clk or posedge rst) begin
        if (rst) begin
            mem_addr <= RESET_PC[PC_W-1:1];
        end else begin
            mem_addr <= pc[PC_W-1:1];
        end
    end

    // Odd nibble address takes the high half
    assign nibble = pc[0] ? mem_data_in[NIBBLE_W +: NIBBLE_W] : mem_data_in[0 +: NIBBLE_W];

endmodule

/* logic/misao_pkg.sv */
package misao_pkg;

    localparam int NIBBLE_W = 4;
    localparam int DATA_W   = 16;
    localparam int ADDR_W   = 15;   // Byte address
    localparam int PC_W     = 16;   // Nibble address

    // Low nibble of byte 1
    localparam logic [PC_W-1:0] RESET_PC = PC_W'(2);

    // Code 3 behaves as LK16
    typedef enum logic [1:0] {
        UL   = 2'd0,
        LK8  = 2'd1,
        LK16 = 2'd2
    } link_e;

    // Opcode is {xop flag, nibble}
    typedef enum logic [4:0] {
        LDI = 5'b00100,
        XOP = 5'b01000,
        CFG = 5'b00010,
        ADD = 5'b00001,
        INC = 5'b01001,
        AND = 5'b00101,
        OR  = 5'b01101,
        SHL = 5'b00011,
        SS  = 5'b01110,
        SUB = 5'b10001,
        DEC = 5'b11001,
        INV = 5'b10101,
        XOR = 5'b11101,
        SHR = 5'b10011
    } op_e;

    typedef logic [1:0] count_t;    // Operand nibbles minus one

    // CFG byte layout
    localparam int CFG_CEN_BIT  = 7;
    localparam int CFG_IMM_BIT  = 3;
    localparam int CFG_LINK_LSB = 0;

    localparam logic CEN_RESET = 1'b1;
    localparam logic IMM_RESET = 1'b0;

endpackage
